//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_img_readout
FILELIST = verilog.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(BUILD)

//--- src/fletcher_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module fletcher_checksum (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        sum_clear,
    input  wire                        sum_en,
    input  wire img_readout_pkg::word_t sum_word,
    output img_readout_pkg::checksum_t sum
);

    // Addition modulo 65535, both operands below 2^16
    function automatic img_readout_pkg::word_t add_mod(
        input img_readout_pkg::word_t x,
        input img_readout_pkg::word_t y
    );
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    img_readout_pkg::word_t a_q;
    img_readout_pkg::word_t b_q;
    img_readout_pkg::word_t swapped;
    img_readout_pkg::word_t a_next;
    img_readout_pkg::word_t b_next;

    // Words are summed as little endian
    assign swapped = {sum_word[7:0], sum_word[15:8]};
    assign a_next  = add_mod(a_q, swapped);
    assign b_next  = add_mod(b_q, a_next);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (sum_clear) begin
            a_q <= '0;
            b_q <= '0;
        end else if (sum_en) begin
            a_q <= a_next;
            b_q <= b_next;
        end
    end

    assign sum = {b_q, a_q};

endmodule

`default_nettype wire

//--- src/img_readout.sv
`timescale 1ns/1ps
`default_nettype none

module img_readout #(
    parameter int img_width     = 4096,
    parameter int img_height    = 4096,
    parameter int header_words  = 8,
    parameter int padding_words = 42
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              cmd_start,
    input  wire img_readout_pkg::readout_cmd_t cmd,
    input  wire                              pix_valid,
    input  wire img_readout_pkg::word_t      pix_data,
    output logic                             pix_ready,
    output logic                             out_valid,
    output img_readout_pkg::word_t           out_data,
    input  wire                              out_ready,
    output logic                             busy,
    output logic                             done
);

    logic                       frame_start;
    logic                       pix_fire;
    logic                       sum_clear;
    logic                       sum_en;
    img_readout_pkg::word_t     sum_word;
    img_readout_pkg::checksum_t sum;
    img_readout_pkg::pix_beat_t beat;

    assign pix_fire = pix_valid && pix_ready;

    // ==============================
    // Frame sequencing
    // ==============================

    readout_sequencer #(
        .header_words  (header_words),
        .padding_words (padding_words),
        .img_width     (img_width),
        .img_height    (img_height)
    ) i_readout_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_start   (cmd_start),
        .cmd         (cmd),
        .pix_valid   (pix_valid),
        .beat        (beat),
        .pix_ready   (pix_ready),
        .frame_start (frame_start),
        .sum_clear   (sum_clear),
        .sum_en      (sum_en),
        .sum_word    (sum_word),
        .sum         (sum),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .busy        (busy),
        .done        (done)
    );

    // ==============================
    // Thumbnail filter and checksum
    // ==============================

    pixel_thumb_filter #(
        .img_width  (img_width),
        .img_height (img_height)
    ) i_pixel_thumb_filter (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .thumb       (cmd.thumb),
        .pix_fire    (pix_fire),
        .pix_data    (pix_data),
        .beat        (beat)
    );

    fletcher_checksum i_fletcher_checksum (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum_clear (sum_clear),
        .sum_en    (sum_en),
        .sum_word  (sum_word),
        .sum       (sum)
    );

endmodule

`default_nettype wire

//--- src/img_readout_pkg.sv
`default_nettype none

package img_readout_pkg;

    // ==============================
    // Stream word
    // ==============================

    // Width of one stream word in bits
    localparam int word_bits = 16;

    // Largest header the command can carry
    localparam int max_header_words = 8;

    // Pixel, header and output words
    typedef logic [word_bits-1:0] word_t;

    // Fletcher-32 result with sum B in the upper half and sum A in the lower half
    typedef logic [2*word_bits-1:0] checksum_t;

    // ==============================
    // Command and pixel beats
    // ==============================

    // Readout command, sampled on the start cycle
    // Most significant header word is sent first
    typedef struct packed {
        logic                                thumb;
        logic [max_header_words*word_bits-1:0] header;
    } readout_cmd_t;

    // Filter verdict travelling with its pixel
    typedef struct packed {
        word_t data;
        logic  keep;
    } pix_beat_t;

endpackage

`default_nettype wire

//--- src/pixel_thumb_filter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_thumb_filter #(
    parameter int img_width  = 4096,
    parameter int img_height = 4096
) (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        frame_start,
    input  wire                        thumb,
    input  wire                        pix_fire,
    input  wire img_readout_pkg::word_t pix_data,
    output img_readout_pkg::pix_beat_t beat
);

    // At least 3 bits so the position inside an 8x8 block is always there
    localparam int col_bits = (img_width > 8) ? $clog2(img_width) : 3;
    localparam int row_bits = (img_height > 8) ? $clog2(img_height) : 3;

    logic [col_bits-1:0] col_q;
    logic [row_bits-1:0] row_q;
    logic                thumb_q;
    logic                in_corner;

    // ==============================
    // Pixel position
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_q   <= '0;
            row_q   <= '0;
            thumb_q <= 1'b0;
        end else if (frame_start) begin
            col_q   <= '0;
            row_q   <= '0;
            thumb_q <= thumb;
        end else if (pix_fire) begin
            if (col_q == col_bits'(img_width - 1)) begin
                col_q <= '0;
                // Row wraps too so a frame never runs off the end
                if (row_q == row_bits'(img_height - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // ==============================
    // Keep decision
    // ==============================

    // Offset 0 or 1 inside the 8x8 block on both axes
    assign in_corner = (col_q[2:1] == 2'b00) && (row_q[2:1] == 2'b00);

    assign beat.data = pix_data;
    assign beat.keep = !thumb_q || in_corner;

endmodule

`default_nettype wire

//--- src/readout_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module readout_sequencer #(
    parameter int header_words  = 8,
    parameter int padding_words = 42,
    parameter int img_width     = 4096,
    parameter int img_height    = 4096
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              cmd_start,
    input  wire img_readout_pkg::readout_cmd_t cmd,
    input  wire                              pix_valid,
    input  wire img_readout_pkg::pix_beat_t  beat,
    output logic                             pix_ready,
    output logic                             frame_start,
    output logic                             sum_clear,
    output logic                             sum_en,
    output img_readout_pkg::word_t           sum_word,
    input  wire img_readout_pkg::checksum_t  sum,
    output logic                             out_valid,
    output img_readout_pkg::word_t           out_data,
    input  wire                              out_ready,
    output logic                             busy,
    output logic                             done
);

    localparam int word_bits     = img_readout_pkg::word_bits;
    localparam int shift_bits    = img_readout_pkg::max_header_words * word_bits;
    localparam int pix_count     = img_width * img_height;
    localparam int pix_bits      = $clog2(pix_count + 1);
    // Two checksum words ahead of the padding
    localparam int trailer_words = padding_words + 2;
    localparam int shift_max     = (header_words > trailer_words) ? header_words
                                                                  : trailer_words;
    localparam int cnt_bits      = $clog2(shift_max);

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_pixels,
        st_wait,
        st_trailer,
        st_finish
    } state_t;

    state_t                  state_q;
    logic [cnt_bits-1:0]     cnt_q;
    logic [pix_bits-1:0]     pix_left_q;
    logic                    wait_q;
    logic [shift_bits-1:0]   shift_q;

    logic                    start_ok;
    logic                    load_ok;
    logic                    hdr_load;
    logic                    pix_fire;
    logic                    pix_load;
    logic                    trl_load;
    logic                    sum_sample;
    img_readout_pkg::word_t  next_word;
    logic [2*word_bits-1:0]  trailer;

    // ==============================
    // Load decisions
    // ==============================

    assign start_ok = (state_q == st_idle) && cmd_start;

    // Output register is free when empty or drained this cycle
    assign load_ok  = !out_valid || out_ready;

    assign hdr_load  = (state_q == st_header) && load_ok;
    assign pix_ready = (state_q == st_pixels) && load_ok;
    assign pix_fire  = pix_valid && pix_ready;
    assign pix_load  = pix_fire && beat.keep;
    assign trl_load  = (state_q == st_trailer) && load_ok;

    // Second wait cycle sees the final sum
    assign sum_sample = (state_q == st_wait) && !wait_q;

    assign next_word = pix_load ? beat.data : shift_q[shift_bits-1 -: word_bits];

    // Checksum bytes in little-endian order
    assign trailer = {sum[7:0], sum[15:8], sum[23:16], sum[31:24]};

    assign frame_start = start_ok;

    // ==============================
    // Frame FSM
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= st_idle;
            cnt_q      <= '0;
            pix_left_q <= '0;
            wait_q     <= 1'b0;
            out_valid  <= 1'b0;
            sum_clear  <= 1'b0;
            sum_en     <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            sum_clear <= start_ok;
            sum_en    <= hdr_load || pix_load;

            if (hdr_load || pix_load || trl_load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end

            case (state_q)
                st_idle: begin
                    if (start_ok) begin
                        state_q <= st_header;
                        cnt_q   <= cnt_bits'(header_words - 1);
                        busy    <= 1'b1;
                        done    <= 1'b0;
                    end
                end
                st_header: begin
                    if (hdr_load) begin
                        if (cnt_q == '0) begin
                            state_q    <= st_pixels;
                            pix_left_q <= pix_bits'(pix_count);
                        end else begin
                            cnt_q <= cnt_q - 1'b1;
                        end
                    end
                end
                st_pixels: begin
                    // Dropped pixels count as well
                    if (pix_fire) begin
                        if (pix_left_q == pix_bits'(1)) begin
                            state_q <= st_wait;
                            wait_q  <= 1'b1;
                        end else begin
                            pix_left_q <= pix_left_q - 1'b1;
                        end
                    end
                end
                st_wait: begin
                    // Enable delay, then the sum register itself
                    if (wait_q) begin
                        wait_q <= 1'b0;
                    end else begin
                        state_q <= st_trailer;
                        cnt_q   <= cnt_bits'(trailer_words - 1);
                    end
                end
                st_trailer: begin
                    if (trl_load) begin
                        if (cnt_q == '0) begin
                            state_q <= st_finish;
                        end else begin
                            cnt_q <= cnt_q - 1'b1;
                        end
                    end
                end
                st_finish: begin
                    // Last padding word leaves the register
                    if (load_ok) begin
                        state_q <= st_idle;
                        busy    <= 1'b0;
                        done    <= 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // ==============================
    // Data path
    // ==============================

    always_ff @(posedge clk) begin
        if (hdr_load || pix_load || trl_load) begin
            out_data <= next_word;
        end
        sum_word <= next_word;

        if (start_ok) begin
            shift_q <= cmd.header;
        end else if (sum_sample) begin
            shift_q <= {trailer, {(shift_bits - 2*word_bits){1'b0}}};
        end else if (hdr_load || trl_load) begin
            // Zeros shift in behind, which makes the padding
            shift_q <= shift_q << word_bits;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_img_readout.sv
`timescale 1ns/1ps
`default_nettype none

module tb_img_readout;

    localparam int img_width      = 16;
    localparam int img_height     = 16;
    localparam int header_words   = 8;
    localparam int padding_words  = 4;
    localparam int pix_count      = img_width * img_height;
    localparam int frame_words    = header_words + pix_count + 2 + padding_words;
    // Tests 2, 3 and 4 plus the two frames of test 5
    localparam int frame_count    = 5;
    localparam int timeout_cycles = 4 * frame_words * frame_count + 2000;
    localparam int word_bits      = img_readout_pkg::word_bits;
    localparam int max_hdr        = img_readout_pkg::max_header_words;

    logic                          clk;
    logic                          arst_n;
    logic                          cmd_start;
    img_readout_pkg::readout_cmd_t cmd;
    logic                          pix_valid;
    img_readout_pkg::word_t        pix_data;
    logic                          pix_ready;
    logic                          out_valid;
    img_readout_pkg::word_t        out_data;
    logic                          out_ready;
    logic                          busy;
    logic                          done;

    img_readout_pkg::word_t        got_q[$];
    img_readout_pkg::word_t        exp_q[$];
    img_readout_pkg::checksum_t    exp_sum;
    int                            errors;
    int                            cycle_cnt = 0;
    integer                        seed;

    img_readout #(
        .img_width     (img_width),
        .img_height    (img_height),
        .header_words  (header_words),
        .padding_words (padding_words)
    ) i_img_readout (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog on the whole run
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_word(input string name, input img_readout_pkg::word_t got,
                              input img_readout_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sum(input string name, input img_readout_pkg::checksum_t got,
                             input img_readout_pkg::checksum_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ==============================
    // Stimulus and reference model
    // ==============================

    function automatic img_readout_pkg::word_t pixel_value(input int n);
        return img_readout_pkg::word_t'(n * 257 + 3);
    endfunction

    // Word i of the header counted from the most significant
    function automatic img_readout_pkg::word_t header_word(
        input img_readout_pkg::readout_cmd_t c, input int i);
        return c.header[(max_hdr - 1 - i) * word_bits +: word_bits];
    endfunction

    function automatic img_readout_pkg::readout_cmd_t make_cmd(
        input logic thumb, input img_readout_pkg::word_t base);
        img_readout_pkg::readout_cmd_t c;
        int i;
        c.thumb  = thumb;
        c.header = '0;
        for (i = 0; i < header_words; i++) begin
            c.header[(max_hdr - 1 - i) * word_bits +: word_bits] =
                base + img_readout_pkg::word_t'(i);
        end
        return c;
    endfunction

    task automatic build_expected(input img_readout_pkg::readout_cmd_t c);
        int a;
        int b;
        int x;
        int y;
        int i;
        img_readout_pkg::word_t w;
        exp_q.delete();
        for (i = 0; i < header_words; i++) begin
            exp_q.push_back(header_word(c, i));
        end
        for (y = 0; y < img_height; y++) begin
            for (x = 0; x < img_width; x++) begin
                if (!c.thumb || ((x % 8) < 2 && (y % 8) < 2)) begin
                    exp_q.push_back(pixel_value(y * img_width + x));
                end
            end
        end
        // Fletcher-32 over header and kept pixels as little endian words
        a = 0;
        b = 0;
        for (i = 0; i < exp_q.size(); i++) begin
            w = {exp_q[i][7:0], exp_q[i][15:8]};
            a = (a + int'(w)) % 65535;
            b = (b + a) % 65535;
        end
        exp_sum = {b[15:0], a[15:0]};
        exp_q.push_back({exp_sum[7:0], exp_sum[15:8]});
        exp_q.push_back({exp_sum[23:16], exp_sum[31:24]});
        for (i = 0; i < padding_words; i++) begin
            exp_q.push_back('0);
        end
    endtask

    // Starts a frame and plays source and sink until done rises
    task automatic run_frame(input img_readout_pkg::readout_cmd_t c, input bit random_bp,
                             input bit mid_start);
        int                     k;
        int                     n;
        bit                     hold;
        bit                     running;
        img_readout_pkg::word_t held;
        logic [31:0]            rnd;
        k       = 0;
        n       = 0;
        hold    = 1'b0;
        running = 1'b1;
        held    = '0;
        got_q.delete();
        while (running) begin
            @(negedge clk);
            cmd_start = (k == 0) || (mid_start && k == 100);
            // Competing command in mid frame that the DUT ignores
            cmd       = (mid_start && k == 100) ? make_cmd(1'b1, 16'h5A00) : c;
            rnd       = $random(seed);
            out_ready = random_bp ? rnd[0] : 1'b1;
            pix_valid = (n < pix_count);
            pix_data  = pixel_value(n);
            #1;
            if (k == 1) begin
                check_bit("out_valid", out_valid, 1'b0);
                check_bit("done", done, 1'b0);
            end
            if (k == 2) begin
                check_bit("out_valid", out_valid, 1'b1);
                check_word("out_data", out_data, header_word(c, 0));
            end
            if (k >= 1 && !done) begin
                check_bit("busy", busy, 1'b1);
            end
            // Word waiting on the sink must not move
            if (hold) begin
                check_bit("out_valid", out_valid, 1'b1);
                check_word("out_data", out_data, held);
            end
            // No pixel is taken while the output word waits on the sink
            if (out_valid && !out_ready) begin
                check_bit("pix_ready", pix_ready, 1'b0);
            end
            if (out_valid && out_ready) begin
                got_q.push_back(out_data);
            end
            if (pix_valid && pix_ready) begin
                n++;
            end
            hold = out_valid && !out_ready;
            held = out_data;
            if (k >= 2 && done) begin
                check_bit("busy", busy, 1'b0);
                running = 1'b0;
            end else if (k > 4 * frame_words + 100) begin
                $display("done did not rise within %0d cycles of the start", k);
                errors++;
                running = 1'b0;
            end
            k++;
        end
    endtask

    task automatic compare_stream(input string what);
        int count;
        int i;
        if (got_q.size() != exp_q.size()) begin
            $display("%s: received %0d words, expected %0d", what, got_q.size(),
                     exp_q.size());
            errors++;
        end
        count = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (i = 0; i < count; i++) begin
            check_word($sformatf("%s out_data[%0d]", what, i), got_q[i], exp_q[i]);
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic check_idle_flags();
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("pix_ready", pix_ready, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
    endtask

    task automatic test_reset_state();
        int i;
        arst_n = 1'b0;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_idle_flags();
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_idle_flags();
    endtask

    task automatic test_full_frame();
        img_readout_pkg::readout_cmd_t c;
        c = make_cmd(1'b0, 16'hA000);
        build_expected(c);
        run_frame(c, 1'b0, 1'b0);
        compare_stream("full frame");
    endtask

    task automatic test_thumb_frame();
        img_readout_pkg::readout_cmd_t c;
        img_readout_pkg::word_t        t0;
        img_readout_pkg::word_t        t1;
        c = make_cmd(1'b1, 16'hA000);
        build_expected(c);
        run_frame(c, 1'b0, 1'b0);
        compare_stream("thumbnail");
        // Trailer sits right after the 16 kept pixels
        if (got_q.size() >= header_words + 18) begin
            t0 = got_q[header_words + 16];
            t1 = got_q[header_words + 17];
            check_sum("trailer checksum", {t1[7:0], t1[15:8], t0[7:0], t0[15:8]}, exp_sum);
        end
    endtask

    task automatic test_back_pressure();
        img_readout_pkg::readout_cmd_t c;
        c = make_cmd(1'b0, 16'hA000);
        build_expected(c);
        run_frame(c, 1'b0 | 1'b1, 1'b0);
        compare_stream("back-pressure");
    endtask

    task automatic test_start_while_busy();
        img_readout_pkg::readout_cmd_t c;
        int                            i;
        c = make_cmd(1'b0, 16'hA000);
        build_expected(c);
        run_frame(c, 1'b0, 1'b1);
        compare_stream("start while busy");
        // done holds while the DUT idles between frames
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            check_bit("done", done, 1'b1);
            check_bit("busy", busy, 1'b0);
        end
        run_frame(c, 1'b0, 1'b0);
        compare_stream("frame after done");
    endtask

    initial begin
        seed      = 32'hf42f913e;
        errors    = 0;
        arst_n    = 1'b0;
        cmd_start = 1'b0;
        cmd       = '0;
        pix_valid = 1'b0;
        pix_data  = '0;
        out_ready = 1'b0;

        test_reset_state();
        test_full_frame();
        test_thumb_frame();
        test_back_pressure();
        test_start_while_busy();

        $display("Summary: %0d errors after %0d cycles", errors, cycle_cnt);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
src/img_readout_pkg.sv
src/pixel_thumb_filter.sv
src/fletcher_checksum.sv
src/readout_sequencer.sv
src/img_readout.sv
tb/tb_img_readout.sv
